//--- hdl/exec_unit.sv
// Decode, register file and execute
`default_nettype none

module exec_unit import rv_lite_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  fetch_if.consumer          fe,
  output logic               ls_req_v_o,
  output logic               ls_we_o,
  output logic [xlen_gp-1:0] ls_addr_o,
  output logic [xlen_gp-1:0] ls_wdata_o,
  input  logic               ls_done_i,
  input  logic [xlen_gp-1:0] ls_rdata_i,
  output logic               halted_o
);

  exec_state_e                  state_r;
  exec_state_e                  state_n;
  logic [xlen_gp-1:0]           instr_r;
  logic [xlen_gp-1:0]           pc_r;
  logic [xlen_gp-1:0]           rf_mem [2**reg_addr_width_gp];

  opcode_e                      opcode;
  logic [2:0]                   funct3;
  logic [reg_addr_width_gp-1:0] rd;
  logic [reg_addr_width_gp-1:0] rs1;
  logic [reg_addr_width_gp-1:0] rs2;
  logic [xlen_gp-1:0]           imm_i;
  logic [xlen_gp-1:0]           imm_s;
  logic [xlen_gp-1:0]           imm_b;
  logic [xlen_gp-1:0]           imm_j;
  logic [xlen_gp-1:0]           rs1_val;
  logic [xlen_gp-1:0]           rs2_val;
  alu_op_e                      alu_op;
  logic                         alu_ok;
  logic [xlen_gp-1:0]           alu_b;
  logic [xlen_gp-1:0]           alu_res;
  logic                         br_taken;
  logic                         rf_we;
  logic [xlen_gp-1:0]           rf_wd;

  // Field extraction
  assign opcode = opcode_e'(instr_r[6:0]);
  assign funct3 = instr_r[14:12];
  assign rd     = instr_r[11:7];
  assign rs1    = instr_r[19:15];
  assign rs2    = instr_r[24:20];
  assign imm_i  = {{20{instr_r[31]}}, instr_r[31:20]};
  assign imm_s  = {{20{instr_r[31]}}, instr_r[31:25], instr_r[11:7]};
  assign imm_b  = {{20{instr_r[31]}}, instr_r[7], instr_r[30:25], instr_r[11:8], 1'b0};
  assign imm_j  = {{12{instr_r[31]}}, instr_r[19:12], instr_r[20], instr_r[30:21], 1'b0};

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_mem[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_mem[rs2];

  // funct3 to ALU op; SLTU, SRA and M-extension encodings fall out as no-ops
  always_comb begin
    alu_op = alu_add;
    alu_ok = (opcode != opc_op) || ((instr_r[31] == 1'b0) && (instr_r[29:25] == '0));
    case (funct3)
      3'b000: alu_op = (opcode == opc_op && instr_r[30]) ? alu_sub : alu_add;
      3'b001: alu_op = alu_sll;
      3'b010: alu_op = alu_slt;
      3'b100: alu_op = alu_xor;
      3'b101: begin
        alu_op = alu_srl;
        alu_ok = alu_ok & ~instr_r[30];
      end
      3'b110: alu_op = alu_or;
      3'b111: alu_op = alu_and;
      default: alu_ok = 1'b0;
    endcase
  end

  assign alu_b = (opcode == opc_op) ? rs2_val : imm_i;

  always_comb begin
    case (alu_op)
      alu_add: alu_res = rs1_val + alu_b;
      alu_sub: alu_res = rs1_val - alu_b;
      alu_and: alu_res = rs1_val & alu_b;
      alu_or:  alu_res = rs1_val | alu_b;
      alu_xor: alu_res = rs1_val ^ alu_b;
      alu_slt: alu_res = {{(xlen_gp-1){1'b0}}, $signed(rs1_val) < $signed(alu_b)};
      alu_sll: alu_res = rs1_val << alu_b[4:0];
      default: alu_res = rs1_val >> alu_b[4:0];
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  br_taken = (rs1_val == rs2_val);
      3'b001:  br_taken = (rs1_val != rs2_val);
      3'b100:  br_taken = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  br_taken = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  br_taken = (rs1_val < rs2_val);
      3'b111:  br_taken = (rs1_val >= rs2_val);
      default: br_taken = 1'b0;
    endcase
  end

  // Sequencing, write-back and redirects
  always_comb begin
    state_n        = state_r;
    rf_we          = 1'b0;
    rf_wd          = alu_res;
    ls_req_v_o     = 1'b0;
    fe.redirect_v  = 1'b0;
    fe.redirect_pc = pc_r + imm_b;
    case (state_r)
      st_wait_instr: if (fe.instr_v) state_n = st_execute;
      st_execute: begin
        state_n = st_wait_instr;
        case (opcode)
          opc_op, opc_op_imm: rf_we = alu_ok;
          opc_lui: begin
            rf_we = 1'b1;
            rf_wd = {instr_r[31:12], 12'b0};
          end
          opc_load, opc_store: begin
            ls_req_v_o = 1'b1;
            state_n    = st_wait_mem;
          end
          opc_branch: fe.redirect_v = br_taken;
          opc_jal: begin
            rf_we          = 1'b1;
            rf_wd          = pc_r + xlen_gp'(4);
            fe.redirect_v  = 1'b1;
            fe.redirect_pc = pc_r + imm_j;
          end
          // Only ECALL halts
          opc_system: if (instr_r[31:7] == '0) state_n = st_halted;
          default: ;
        endcase
      end
      st_wait_mem: begin
        if (ls_done_i) begin
          state_n = st_wait_instr;
          rf_we   = (opcode == opc_load);
          rf_wd   = ls_rdata_i;
        end
      end
      default: state_n = st_halted;
    endcase
  end

  assign ls_we_o    = (opcode == opc_store);
  assign ls_addr_o  = rs1_val + ((opcode == opc_store) ? imm_s : imm_i);
  assign ls_wdata_o = rs2_val;
  assign fe.ready   = (state_r == st_wait_instr);
  assign halted_o   = (state_r == st_halted);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_wait_instr;
    end else begin
      state_r <= state_n;
    end
  end

  // Instruction latch and register file writes
  always_ff @(posedge clk_i) begin
    if (fe.ready && fe.instr_v) begin
      instr_r <= fe.instr;
      pc_r    <= fe.pc;
    end
    if (rf_we && rd != '0) begin
      rf_mem[rd] <= rf_wd;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
// Instruction fetch with one-ahead prefetch
`default_nettype none

module fetch_unit import rv_lite_pkg::*; #(
  parameter logic [xlen_gp-1:0] reset_pc_p = '0
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  mem_bus_if.requester  bus,
  fetch_if.producer     fe
);

  // Next address to fetch
  logic [xlen_gp-1:0] pc_r;
  // One request slot, pending on the bus or waiting for its response
  logic               req_v_r;
  logic [xlen_gp-1:0] req_addr_r;
  logic               inflight_r;
  // Slot belongs to a path that a redirect abandoned
  logic               discard_r;
  // One-entry instruction buffer
  logic               buf_v_r;
  logic [xlen_gp-1:0] buf_instr_r;
  logic [xlen_gp-1:0] buf_pc_r;

  logic               take;
  logic               launch;
  logic               rsp_keep;
  logic [xlen_gp-1:0] launch_pc;

  assign take = buf_v_r & fe.ready;
  // New request once the slot is empty and the buffer is free or being freed
  assign launch = ~req_v_r & ~inflight_r & (~buf_v_r | take | fe.redirect_v);
  assign launch_pc = fe.redirect_v ? fe.redirect_pc : pc_r;
  // A response in the redirect cycle belongs to the old path too
  assign rsp_keep = bus.rsp_v & ~discard_r & ~fe.redirect_v;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_r       <= reset_pc_p;
      req_v_r    <= 1'b0;
      inflight_r <= 1'b0;
      discard_r  <= 1'b0;
      buf_v_r    <= 1'b0;
    end else begin
      if (launch) begin
        req_v_r <= 1'b1;
        pc_r    <= launch_pc + xlen_gp'(4);
      end else if (fe.redirect_v) begin
        pc_r <= fe.redirect_pc;
      end
      if (req_v_r && bus.yumi) begin
        req_v_r    <= 1'b0;
        inflight_r <= 1'b1;
      end
      if (bus.rsp_v) begin
        inflight_r <= 1'b0;
        discard_r  <= 1'b0;
      end
      // Old request still has to drain through the arbiter
      if (fe.redirect_v && (req_v_r || inflight_r) && !bus.rsp_v) begin
        discard_r <= 1'b1;
      end
      if (fe.redirect_v) begin
        buf_v_r <= 1'b0;
      end else if (rsp_keep) begin
        buf_v_r <= 1'b1;
      end else if (take) begin
        buf_v_r <= 1'b0;
      end
    end
  end

  // Request address and buffered word
  always_ff @(posedge clk_i) begin
    if (launch) begin
      req_addr_r <= launch_pc;
    end
    if (rsp_keep) begin
      buf_instr_r <= bus.rdata;
      buf_pc_r    <= req_addr_r;
    end
  end

  assign bus.req_v  = req_v_r;
  assign bus.we     = 1'b0;
  assign bus.addr   = req_addr_r;
  assign bus.wdata  = '0;

  assign fe.instr_v = buf_v_r;
  assign fe.instr   = buf_instr_r;
  assign fe.pc      = buf_pc_r;

endmodule

`default_nettype wire

//--- hdl/load_store_unit.sv
// Word load and store requester
`default_nettype none

module load_store_unit import rv_lite_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ls_req_v_i,
  input  logic               ls_we_i,
  input  logic [xlen_gp-1:0] ls_addr_i,
  input  logic [xlen_gp-1:0] ls_wdata_i,
  output logic               ls_done_o,
  output logic [xlen_gp-1:0] ls_rdata_o,
  mem_bus_if.requester       bus
);

  // Request held on the bus until yumi
  logic               req_v_r;
  // Read accepted, response outstanding
  logic               wait_rsp_r;
  logic               we_r;
  logic [xlen_gp-1:0] addr_r;
  logic [xlen_gp-1:0] wdata_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_v_r    <= 1'b0;
      wait_rsp_r <= 1'b0;
    end else begin
      if (ls_req_v_i) begin
        req_v_r <= 1'b1;
      end else if (bus.yumi) begin
        req_v_r <= 1'b0;
      end
      if (req_v_r && bus.yumi && !we_r) begin
        wait_rsp_r <= 1'b1;
      end else if (bus.rsp_v) begin
        wait_rsp_r <= 1'b0;
      end
    end
  end

  // Capture once so execute can drop its lines after one cycle
  always_ff @(posedge clk_i) begin
    if (ls_req_v_i) begin
      we_r    <= ls_we_i;
      addr_r  <= ls_addr_i;
      wdata_r <= ls_wdata_i;
    end
  end

  assign bus.req_v = req_v_r;
  assign bus.we    = we_r;
  assign bus.addr  = addr_r;
  assign bus.wdata = wdata_r;

  // Writes complete on acceptance, reads on their response
  assign ls_done_o  = (req_v_r & bus.yumi & we_r) | (wait_rsp_r & bus.rsp_v);
  assign ls_rdata_o = bus.rdata;

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
// Shared memory port arbiter
`default_nettype none

module mem_arbiter import rv_lite_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  mem_bus_if.arbiter         fetch_bus,
  mem_bus_if.arbiter         data_bus,
  output logic               mem_req_v_o,
  output logic               mem_req_we_o,
  output logic [xlen_gp-1:0] mem_req_addr_o,
  output logic [xlen_gp-1:0] mem_req_wdata_o,
  input  logic               mem_req_yumi_i,
  input  logic               mem_rsp_v_i,
  input  logic [xlen_gp-1:0] mem_rsp_data_i
);

  arb_state_e state_r;
  arb_state_e state_n;
  // Read accepted by memory, grant waits for its response
  logic       issued_r;
  logic       sel_data;
  logic       sel_fetch;
  logic       req_fire;

  // Idle grants combinationally with data first, busy keeps the owner
  always_comb begin
    sel_data  = 1'b0;
    sel_fetch = 1'b0;
    case (state_r)
      arb_idle: begin
        sel_data  = data_bus.req_v;
        sel_fetch = ~data_bus.req_v & fetch_bus.req_v;
      end
      arb_fetch_busy: sel_fetch = 1'b1;
      arb_data_busy:  sel_data  = 1'b1;
      default: ;
    endcase
  end

  assign mem_req_v_o = ~issued_r & ((sel_data & data_bus.req_v) | (sel_fetch & fetch_bus.req_v));
  assign mem_req_we_o    = sel_data ? data_bus.we    : fetch_bus.we;
  assign mem_req_addr_o  = sel_data ? data_bus.addr  : fetch_bus.addr;
  assign mem_req_wdata_o = sel_data ? data_bus.wdata : fetch_bus.wdata;
  assign req_fire = mem_req_v_o & mem_req_yumi_i;

  // Handshake and response only reach the owner
  assign data_bus.yumi   = sel_data & req_fire;
  assign fetch_bus.yumi  = sel_fetch & req_fire;
  assign data_bus.rsp_v  = sel_data & issued_r & mem_rsp_v_i;
  assign fetch_bus.rsp_v = sel_fetch & issued_r & mem_rsp_v_i;
  assign data_bus.rdata  = sel_data ? mem_rsp_data_i : '0;
  assign fetch_bus.rdata = sel_fetch ? mem_rsp_data_i : '0;

  always_comb begin
    state_n = state_r;
    if (state_r == arb_idle) begin
      if (sel_data) begin
        state_n = arb_data_busy;
      end else if (sel_fetch) begin
        state_n = arb_fetch_busy;
      end
    end
    // Release on write acceptance or read response
    if ((req_fire && mem_req_we_o) || (issued_r && mem_rsp_v_i)) begin
      state_n = arb_idle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r  <= arb_idle;
      issued_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (req_fire && !mem_req_we_o) begin
        issued_r <= 1'b1;
      end else if (mem_rsp_v_i) begin
        issued_r <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_lite_ifs.sv
// Internal bus interfaces
`default_nettype none

// Word request/response link with valid/yumi handshake
interface mem_bus_if import rv_lite_pkg::*; ();
  logic               req_v;
  logic               we;
  logic [xlen_gp-1:0] addr;
  logic [xlen_gp-1:0] wdata;
  logic               yumi;
  logic               rsp_v;
  logic [xlen_gp-1:0] rdata;

  // Fetch or load-store side
  modport requester (
    output req_v, we, addr, wdata,
    input  yumi, rsp_v, rdata
  );

  // Arbiter side
  modport arbiter (
    input  req_v, we, addr, wdata,
    output yumi, rsp_v, rdata
  );
endinterface

// Instruction handoff and redirect between fetch and execute
interface fetch_if import rv_lite_pkg::*; ();
  logic               instr_v;
  logic [xlen_gp-1:0] instr;
  logic [xlen_gp-1:0] pc;
  logic               ready;
  logic               redirect_v;
  logic [xlen_gp-1:0] redirect_pc;

  modport producer (
    output instr_v, instr, pc,
    input  ready, redirect_v, redirect_pc
  );

  modport consumer (
    input  instr_v, instr, pc,
    output ready, redirect_v, redirect_pc
  );
endinterface

`default_nettype wire

//--- hdl/rv_lite_pkg.sv
// Core-wide definitions
`default_nettype none

package rv_lite_pkg;

  // Data and address width
  parameter int xlen_gp = 32;
  // Register index width, 32 architectural registers
  parameter int reg_addr_width_gp = 5;

  // Major opcodes, encoded as instr[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl
  } alu_op_e;

  // Execute sequencing
  typedef enum logic [1:0] {
    st_wait_instr,
    st_execute,
    st_wait_mem,
    st_halted
  } exec_state_e;

  // Memory port ownership
  typedef enum logic [1:0] {
    arb_idle,
    arb_fetch_busy,
    arb_data_busy
  } arb_state_e;

endpackage

`default_nettype wire

//--- hdl/rv_lite_top.sv
// Core top level
`default_nettype none

module rv_lite_top import rv_lite_pkg::*; #(
  parameter logic [xlen_gp-1:0] reset_pc_p = '0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  output logic               mem_req_v_o,
  output logic               mem_req_we_o,
  output logic [xlen_gp-1:0] mem_req_addr_o,
  output logic [xlen_gp-1:0] mem_req_wdata_o,
  input  logic               mem_req_yumi_i,
  input  logic               mem_rsp_v_i,
  input  logic [xlen_gp-1:0] mem_rsp_data_i,
  output logic               halted_o
);

  // Execute to load-store request lines
  logic               ls_req_v;
  logic               ls_we;
  logic [xlen_gp-1:0] ls_addr;
  logic [xlen_gp-1:0] ls_wdata;
  logic               ls_done;
  logic [xlen_gp-1:0] ls_rdata;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();
  fetch_if   fe_if ();

  fetch_unit #(
    .reset_pc_p (reset_pc_p)
  ) fetch_unit_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (fetch_bus.requester),
    .fe      (fe_if.producer)
  );

  exec_unit exec_unit_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fe         (fe_if.consumer),
    .ls_req_v_o (ls_req_v),
    .ls_we_o    (ls_we),
    .ls_addr_o  (ls_addr),
    .ls_wdata_o (ls_wdata),
    .ls_done_i  (ls_done),
    .ls_rdata_i (ls_rdata),
    .halted_o   (halted_o)
  );

  load_store_unit load_store_unit_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ls_req_v_i (ls_req_v),
    .ls_we_i    (ls_we),
    .ls_addr_i  (ls_addr),
    .ls_wdata_i (ls_wdata),
    .ls_done_o  (ls_done),
    .ls_rdata_o (ls_rdata),
    .bus        (data_bus.requester)
  );

  // Arbiter owns the external port
  mem_arbiter mem_arbiter_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_bus       (fetch_bus.arbiter),
    .data_bus        (data_bus.arbiter),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_yumi_i  (mem_req_yumi_i),
    .mem_rsp_v_i     (mem_rsp_v_i),
    .mem_rsp_data_i  (mem_rsp_data_i)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_lite testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f rv_lite.f --top-module rv_lite_tb -o Vrv_lite_tb

output="$(./obj_dir/Vrv_lite_tb)"
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
  exit 0
else
  exit 1
fi

//--- rv_lite.f
+incdir+verification
hdl/rv_lite_pkg.sv
hdl/rv_lite_ifs.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/exec_unit.sv
hdl/rv_lite_top.sv
verification/rv_lite_tb.sv

//--- verification/rv_lite_ref_model.svh
// Instruction-set reference and programs
`ifndef RV_LITE_REF_MODEL_SVH
`define RV_LITE_REF_MODEL_SVH

// Instruction encoders
function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(int imm20, int rd);
  return {imm20[19:0], rd[4:0], 7'h37};
endfunction

function automatic logic [31:0] enc_j(int imm, int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

function void emit(logic [31:0] word);
  prog[prog_len[7:0]] = word;
  prog_len++;
endfunction

// Store a register into the data area based at x10
function void emit_sw(int rs, int off);
  emit(enc_s(off, rs, 10));
endfunction

// Program images, 0 ALU, 1 load/store, 2 control flow
task automatic build_prog(input int id);
  prog_len = 0;
  emit(enc_i(768, 0, 0, 10, 7'h13));
  case (id)
    0: begin
      emit(enc_i(123, 0, 0, 1, 7'h13));
      emit(enc_i(-45, 0, 0, 2, 7'h13));
      emit(enc_r(0, 2, 1, 0, 3));
      emit_sw(3, 0);
      emit(enc_r(32, 2, 1, 0, 4));
      emit_sw(4, 4);
      emit(enc_r(0, 2, 1, 7, 5));
      emit_sw(5, 8);
      emit(enc_r(0, 2, 1, 6, 6));
      emit_sw(6, 12);
      emit(enc_r(0, 2, 1, 4, 7));
      emit_sw(7, 16);
      emit(enc_r(0, 1, 2, 2, 8));
      emit_sw(8, 20);
      emit(enc_i(5, 0, 0, 9, 7'h13));
      emit(enc_r(0, 9, 1, 1, 11));
      emit_sw(11, 24);
      emit(enc_r(0, 9, 2, 5, 12));
      emit_sw(12, 28);
      emit(enc_i(240, 2, 7, 13, 7'h13));
      emit_sw(13, 32);
      emit(enc_i(-256, 1, 6, 14, 7'h13));
      emit_sw(14, 36);
      emit(enc_i(1365, 2, 4, 15, 7'h13));
      emit_sw(15, 40);
      emit(enc_i(-44, 2, 2, 16, 7'h13));
      emit_sw(16, 44);
      emit(enc_i(7, 2, 1, 17, 7'h13));
      emit_sw(17, 48);
      emit(enc_i(3, 2, 5, 18, 7'h13));
      emit_sw(18, 52);
      emit(enc_u(32'habcde, 19));
      emit_sw(19, 56);
      emit(enc_i(-1, 19, 0, 19, 7'h13));
      emit_sw(19, 60);
    end
    1: begin
      emit(enc_i(85, 0, 0, 1, 7'h13));
      emit_sw(1, 0);
      emit(enc_u(32'h12345, 2));
      emit(enc_i(1656, 2, 0, 2, 7'h13));
      emit_sw(2, 4);
      emit(enc_i(0, 10, 2, 3, 7'h03));
      emit(enc_i(4, 10, 2, 4, 7'h03));
      emit(enc_r(0, 4, 3, 0, 5));
      emit_sw(5, 8);
      // Word from the fill pattern
      emit(enc_i(64, 10, 2, 6, 7'h03));
      emit(enc_r(0, 5, 6, 4, 7));
      emit_sw(7, 12);
      emit_sw(6, 16);
    end
    default: begin
      emit(enc_i(5, 0, 0, 1, 7'h13));
      emit(enc_i(5, 0, 0, 2, 7'h13));
      emit(enc_b(8, 2, 1, 0));
      emit_sw(1, 0);
      emit(enc_b(8, 2, 1, 1));
      emit_sw(2, 4);
      emit(enc_i(-1, 0, 0, 3, 7'h13));
      emit(enc_b(8, 1, 3, 4));
      emit_sw(3, 8);
      // Four passes adding 3
      emit(enc_i(0, 0, 0, 4, 7'h13));
      emit(enc_i(4, 0, 0, 5, 7'h13));
      emit(enc_i(3, 4, 0, 4, 7'h13));
      emit(enc_i(-1, 5, 0, 5, 7'h13));
      emit(enc_b(-8, 0, 5, 1));
      emit_sw(4, 12);
      emit(enc_j(12, 6));
      emit_sw(0, 16);
      emit_sw(0, 20);
      emit_sw(6, 24);
      emit(enc_b(8, 3, 1, 4));
      emit_sw(1, 28);
      // Unequal operands fall through
      emit(enc_b(8, 3, 1, 0));
      emit_sw(3, 32);
    end
  endcase
  emit(32'h0000_0073);
endtask

// Run ref_mem from the reset PC to ECALL, return the instruction count
function automatic int ref_run();
  logic [31:0] x [32];
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] src;
  logic [31:0] res;
  logic [31:0] immi;
  logic [31:0] addr;
  logic        wr;
  logic        cond;
  int          steps;
  for (int i = 0; i < 32; i++) begin
    x[i] = '0;
  end
  pc = reset_pc_lp;
  steps = 0;
  while (steps < 4000) begin
    ins = ref_mem[pc[9:2]];
    steps++;
    next_pc = pc + 32'd4;
    a = x[ins[19:15]];
    b = x[ins[24:20]];
    immi = {{20{ins[31]}}, ins[31:20]};
    wr = 1'b0;
    res = '0;
    case (ins[6:0])
      7'h33, 7'h13: begin
        src = (ins[6:0] == 7'h33) ? b : immi;
        wr = 1'b1;
        case (ins[14:12])
          3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - src : a + src;
          3'd1: res = a << src[4:0];
          3'd2: res = {31'b0, $signed(a) < $signed(src)};
          3'd4: res = a ^ src;
          3'd5: res = a >> src[4:0];
          3'd6: res = a | src;
          3'd7: res = a & src;
          default: wr = 1'b0;
        endcase
      end
      7'h37: begin
        wr = 1'b1;
        res = {ins[31:12], 12'b0};
      end
      7'h03: begin
        wr = 1'b1;
        addr = a + immi;
        res = ref_mem[addr[9:2]];
      end
      7'h23: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ref_mem[addr[9:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      7'h63: begin
        case (ins[14:12])
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          3'd7: cond = (a >= b);
          default: cond = 1'b0;
        endcase
        if (cond) begin
          next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'h6f: begin
        wr = 1'b1;
        res = pc + 32'd4;
        next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'h73: return steps;
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      x[ins[11:7]] = res;
    end
    pc = next_pc;
  end
  return steps;
endfunction

`endif

//--- verification/rv_lite_tb.sv
// Core testbench
`default_nettype none

module rv_lite_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] reset_pc_lp = 32'h0000_0040;

  logic        clk_i;
  logic        rst_n_i;
  logic        mem_req_v_o;
  logic        mem_req_we_o;
  logic [31:0] mem_req_addr_o;
  logic [31:0] mem_req_wdata_o;
  logic        mem_req_yumi_i;
  logic        mem_rsp_v_i;
  logic [31:0] mem_rsp_data_i;
  logic        halted_o;

  // Memory model, program image and reference copy
  logic [31:0] mem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] prog [256];
  int          prog_len;
  // Expected store trace
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          store_idx;
  int          err_cnt;
  int          tests_run;
  int          tests_failed;
  int          budget_cycles;
  logic        budget_set;
  // Random delay state
  logic [31:0] lfsr_q;
  logic        rand_en;
  int          acc_cnt;
  int          rsp_cnt;
  logic        rsp_pend;
  logic [31:0] rsp_word;
  logic        fire;

  `include "rv_lite_ref_model.svh"

  rv_lite_top #(
    .reset_pc_p (reset_pc_lp)
  ) rv_lite_top_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_yumi_i  (mem_req_yumi_i),
    .mem_rsp_v_i     (mem_rsp_v_i),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .halted_o        (halted_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken
  function int rand_bits(int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = (r << 1) | {31'b0, lfsr_q[0]};
    end
    return r;
  endfunction

  function int mem_delay();
    return rand_en ? rand_bits(2) : 0;
  endfunction

  // Word memory with accept and response delays
  always @(posedge clk_i) begin
    fire = mem_req_v_o && mem_req_yumi_i;
    if (fire && mem_req_we_o) begin
      mem[mem_req_addr_o[9:2]] = mem_req_wdata_o;
    end else if (fire) begin
      rsp_pend = 1'b1;
      rsp_word = mem[mem_req_addr_o[9:2]];
      rsp_cnt  = mem_delay();
    end
    #2;
    mem_rsp_v_i = 1'b0;
    if (rsp_pend && rsp_cnt == 0) begin
      mem_rsp_v_i    = 1'b1;
      mem_rsp_data_i = rsp_word;
      rsp_pend       = 1'b0;
    end else if (rsp_pend) begin
      rsp_cnt--;
    end
    if (fire) begin
      acc_cnt = mem_delay();
    end
    mem_req_yumi_i = 1'b0;
    if (mem_req_v_o && acc_cnt == 0) begin
      mem_req_yumi_i = 1'b1;
    end else if (mem_req_v_o) begin
      acc_cnt--;
    end
  end

  // Compare every accepted write with the reference trace
  always @(posedge clk_i) begin
    if (rst_n_i && mem_req_v_o && mem_req_yumi_i && mem_req_we_o) begin
      if (store_idx >= exp_addr.size()) begin
        $display("ERROR at %0t: unexpected store %h to %h", $time, mem_req_wdata_o,
                 mem_req_addr_o);
        err_cnt++;
      end else if (mem_req_addr_o != exp_addr[store_idx] ||
                   mem_req_wdata_o != exp_data[store_idx]) begin
        $display("ERROR at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                 store_idx, mem_req_wdata_o, mem_req_addr_o, exp_data[store_idx],
                 exp_addr[store_idx]);
        err_cnt++;
      end
      store_idx++;
    end
  end

  // Fill pattern, program at the reset PC, reference copy and expected trace
  task automatic load_image(input int id);
    build_prog(id);
    for (int i = 0; i < 256; i++) begin
      mem[i[7:0]] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    end
    for (int i = 0; i < prog_len; i++) begin
      mem[i[7:0] + reset_pc_lp[9:2]] = prog[i[7:0]];
    end
    ref_mem = mem;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic run_prog(input string name, input int id, input logic rnd);
    int errs0;
    int steps;
    int cnt;
    logic quiet_bad;
    errs0 = err_cnt;
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b0;
    load_image(id);
    steps = ref_run();
    store_idx = 0;
    rand_en = rnd;
    acc_cnt = 0;
    rsp_pend = 1'b0;
    // Outputs stay low through reset, looked at once each edge has settled
    repeat (10) begin
      @(posedge clk_i);
      #1;
      if (mem_req_v_o || halted_o) begin
        $display("ERROR at %0t: request or halt seen during reset", $time);
        err_cnt++;
      end
    end
    #1;
    rst_n_i = 1'b1;
    cnt = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while (!mem_req_v_o && cnt < 20);
    if (!mem_req_v_o || mem_req_we_o || mem_req_addr_o != reset_pc_lp) begin
      $display("ERROR at %0t: first request is not a read of the reset PC", $time);
      err_cnt++;
    end
    cnt = 0;
    while (!halted_o && cnt < steps * 30 + 100) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!halted_o) begin
      $display("%s: core did not halt after ECALL", name);
      err_cnt++;
    end
    // Let a prefetch issued before the halt drain
    cnt = 0;
    while ((mem_req_v_o || rsp_pend) && cnt < 20) begin
      @(posedge clk_i);
      cnt++;
    end
    quiet_bad = 1'b0;
    repeat (50) begin
      @(posedge clk_i);
      if (mem_req_v_o || !halted_o) begin
        quiet_bad = 1'b1;
      end
    end
    if (quiet_bad) begin
      $display("ERROR at %0t: request or halt drop after ECALL", $time);
      err_cnt++;
    end
    if (store_idx != exp_addr.size()) begin
      $display("ERROR at %0t: %0d stores seen, expected %0d", $time, store_idx,
               exp_addr.size());
      err_cnt++;
    end
    if (mem != ref_mem) begin
      $display("ERROR at %0t: final memory differs from the reference", $time);
      err_cnt++;
    end
    tests_run++;
    if (err_cnt != errs0) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs0);
    end else begin
      $display("test %s: ok, %0d stores", name, store_idx);
    end
  endtask

  // Watchdog sized from the reference instruction counts
  initial begin
    wait (budget_set);
    repeat (budget_cycles) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", budget_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int total;
    rst_n_i        = 1'b0;
    mem_req_yumi_i = 1'b0;
    mem_rsp_v_i    = 1'b0;
    mem_rsp_data_i = '0;
    lfsr_q         = 32'hd528_9d21;
    rand_en        = 1'b0;
    rsp_pend       = 1'b0;
    acc_cnt        = 0;
    rsp_cnt        = 0;
    store_idx      = 0;
    err_cnt        = 0;
    tests_run      = 0;
    tests_failed   = 0;
    budget_set     = 1'b0;
    total = 0;
    for (int id = 0; id < 3; id++) begin
      load_image(id);
      total += ref_run();
    end
    // Zero-delay and random-delay pass of each program
    budget_cycles = 2 * total * 30 + 6 * 300;
    budget_set = 1'b1;
    run_prog("alu", 0, 1'b0);
    run_prog("load_store", 1, 1'b0);
    run_prog("control_flow", 2, 1'b0);
    run_prog("alu_backpressure", 0, 1'b1);
    run_prog("load_store_backpressure", 1, 1'b1);
    run_prog("control_flow_backpressure", 2, 1'b1);
    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
